//--- Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl #(
  parameter int NUM_LINES = 32
) (
  input  logic                                               clock,
  input  logic                                               reset,
  input  logic [icache_pkg::FETCH_ADDR_W-1:0]                fetch_addr,
  input  icache_pkg::mem_rsp_t                               mem_rsp,
  input  logic                                               hit,
  input  logic [icache_pkg::DATA_W-1:0]                      hit_data,
  output logic [icache_pkg::index_bits(NUM_LINES)-1:0]       rd_index,
  output logic [icache_pkg::tag_bits(NUM_LINES)-1:0]         rd_tag,
  output icache_pkg::mem_cmd_e                               mem_cmd,
  output logic [icache_pkg::PADDR_W-1:0]                     mem_addr,
  output logic                                               wr_en,
  output logic [icache_pkg::index_bits(NUM_LINES)-1:0]       wr_index,
  output logic [icache_pkg::tag_bits(NUM_LINES)-1:0]         wr_tag,
  output logic [icache_pkg::DATA_W-1:0]                      wr_data,
  output logic [icache_pkg::DATA_W-1:0]                      fetch_data,
  output logic                                               fetch_valid
);

  localparam int INDEX_W = icache_pkg::index_bits(NUM_LINES);
  localparam int TAG_W   = icache_pkg::tag_bits(NUM_LINES);

  logic [INDEX_W-1:0] cur_index, last_index, pend_index;
  logic [TAG_W-1:0]   cur_tag, last_tag, pend_tag;
  logic [icache_pkg::RSP_TAG_W-1:0] pend_rsp;  // nonzero while a fill is owed
  logic miss_outstanding;
  logic changed_addr;
  logic accepted;
  logic fill_match;
  logic next_miss;

  assign {cur_tag, cur_index} = fetch_addr[icache_pkg::PADDR_W-1:icache_pkg::ADDR_LSB];

  assign changed_addr = (cur_index != last_index) || (cur_tag != last_tag);

  assign mem_cmd  = (miss_outstanding && !changed_addr) ? icache_pkg::BUS_LOAD
                                                        : icache_pkg::BUS_NONE;
  assign mem_addr = {fetch_addr[icache_pkg::PADDR_W-1:icache_pkg::ADDR_LSB],
                     {icache_pkg::ADDR_LSB{1'b0}}};  // word aligned

  assign accepted   = (mem_cmd == icache_pkg::BUS_LOAD) && (mem_rsp.response != '0);
  assign fill_match = (pend_rsp != '0) && (mem_rsp.tag == pend_rsp);

  // a fresh address misses unless present; an old miss waits for an accept
  assign next_miss = changed_addr ? !hit : (miss_outstanding && !accepted);

  assign rd_index = cur_index;
  assign rd_tag   = cur_tag;

  assign wr_en    = fill_match;
  assign wr_index = pend_index;  // fill goes where the miss was recorded
  assign wr_tag   = pend_tag;
  assign wr_data  = mem_rsp.data;

  assign fetch_data  = hit_data;
  assign fetch_valid = hit;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      last_index       <= '1;  // all ones so the first address looks new
      last_tag         <= '1;
      miss_outstanding <= 1'b0;
      pend_rsp         <= '0;
    end
    else
    begin
      last_index       <= cur_index;
      last_tag         <= cur_tag;
      miss_outstanding <= next_miss;
      if (accepted)
        pend_rsp <= mem_rsp.response;
      else if (fill_match)
        pend_rsp <= '0;  // record retired once the data is written
    end
  end

  always_ff @(posedge clock)
  begin
    if (accepted)
    begin
      pend_index <= cur_index;
      pend_tag   <= cur_tag;
    end
  end

endmodule

//--- hw/icache_mem.sv
`timescale 1ns/1ns

module icache_mem #(
  parameter int NUM_LINES = 32
) (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic [icache_pkg::index_bits(NUM_LINES)-1:0] rd_index,
  input  logic [icache_pkg::tag_bits(NUM_LINES)-1:0]   rd_tag,
  input  logic                                         wr_en,
  input  logic [icache_pkg::index_bits(NUM_LINES)-1:0] wr_index,
  input  logic [icache_pkg::tag_bits(NUM_LINES)-1:0]   wr_tag,
  input  logic [icache_pkg::DATA_W-1:0]                wr_data,
  output logic                                         hit,
  output logic [icache_pkg::DATA_W-1:0]                hit_data
);

  localparam int LINE_TAG_W = icache_pkg::LINE_TAG_W;

  icache_pkg::cache_line_t lines [NUM_LINES];
  icache_pkg::cache_line_t rd_line;
  icache_pkg::cache_line_t wr_line;

  // stored tag field is sized for the default geometry
  assign rd_line = lines[rd_index];
  assign hit     = rd_line.valid && (rd_line.tag == LINE_TAG_W'(rd_tag));
  assign hit_data = rd_line.data;

  always_comb
  begin
    wr_line.valid = 1'b1;
    wr_line.tag   = LINE_TAG_W'(wr_tag);
    wr_line.data  = wr_data;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_LINES; i++)
        lines[i].valid <= 1'b0;  // only valid bits are cleared
    end
    else if (wr_en)
    begin
      lines[wr_index] <= wr_line;  // a fill overwrites whatever was there
    end
  end

endmodule

//--- hw/icache_pkg.sv
package icache_pkg;

  localparam int FETCH_ADDR_W  = 64;  // processor fetch address width
  localparam int PADDR_W       = 32;  // external memory address width
  localparam int ADDR_LSB      = 3;   // byte offset within a 64-bit word
  localparam int DATA_W        = 64;
  localparam int RSP_TAG_W     = 4;   // zero is reserved for "nothing"
  localparam int DEFAULT_LINES = 32;

  // index and tag together cover paddr bits 31 down to ADDR_LSB
  function automatic int index_bits(int num_lines);
    return $clog2(num_lines);
  endfunction

  function automatic int tag_bits(int num_lines);
    return PADDR_W - ADDR_LSB - $clog2(num_lines);
  endfunction

  localparam int LINE_TAG_W = tag_bits(DEFAULT_LINES);  // 24 bits for 32 lines

  typedef enum logic [1:0] {
    BUS_NONE = 2'd0,
    BUS_LOAD = 2'd1
  } mem_cmd_e;

  typedef struct packed {
    logic [RSP_TAG_W-1:0] response;  // tag handed out on accept
    logic [DATA_W-1:0]    data;
    logic [RSP_TAG_W-1:0] tag;       // tag of the data returned this cycle
  } mem_rsp_t;

  typedef struct packed {
    logic [PADDR_W-1:0] paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
  } apb_req_t;

  typedef struct packed {
    logic                  valid;
    logic [LINE_TAG_W-1:0] tag;
    logic [DATA_W-1:0]     data;
  } cache_line_t;

endpackage

//--- hw/icache_top.sv
`timescale 1ns/1ns

module icache_top #(
  parameter int NUM_LINES = 32
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [icache_pkg::FETCH_ADDR_W-1:0] fetch_addr,
  input  logic [icache_pkg::DATA_W-1:0]       prdata,
  input  logic                                pready,
  output logic [icache_pkg::DATA_W-1:0]       fetch_data,
  output logic                                fetch_valid,
  output icache_pkg::apb_req_t                apb
);

  localparam int INDEX_W = icache_pkg::index_bits(NUM_LINES);
  localparam int TAG_W   = icache_pkg::tag_bits(NUM_LINES);

  logic [INDEX_W-1:0]              rd_index, wr_index;
  logic [TAG_W-1:0]                rd_tag, wr_tag;
  logic [icache_pkg::DATA_W-1:0]   hit_data, wr_data;
  logic                            hit, wr_en;
  logic [icache_pkg::PADDR_W-1:0]  mem_addr;
  icache_pkg::mem_cmd_e            mem_cmd;
  icache_pkg::mem_rsp_t            mem_rsp;

  icache_ctrl #(
    .NUM_LINES (NUM_LINES)
  ) ctrl0 (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .mem_rsp     (mem_rsp),
    .hit         (hit),
    .hit_data    (hit_data),
    .rd_index    (rd_index),
    .rd_tag      (rd_tag),
    .mem_cmd     (mem_cmd),
    .mem_addr    (mem_addr),
    .wr_en       (wr_en),
    .wr_index    (wr_index),
    .wr_tag      (wr_tag),
    .wr_data     (wr_data),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid)
  );

  icache_mem #(
    .NUM_LINES (NUM_LINES)
  ) mem0 (
    .clock    (clock),
    .reset    (reset),
    .rd_index (rd_index),
    .rd_tag   (rd_tag),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_tag   (wr_tag),
    .wr_data  (wr_data),
    .hit      (hit),
    .hit_data (hit_data)
  );

  imem_apb_bridge bridge0 (
    .clock    (clock),
    .reset    (reset),
    .mem_cmd  (mem_cmd),
    .mem_addr (mem_addr),
    .prdata   (prdata),
    .pready   (pready),
    .mem_rsp  (mem_rsp),
    .apb      (apb)
  );

endmodule

//--- hw/imem_apb_bridge.sv
`timescale 1ns/1ns

module imem_apb_bridge (
  input  logic                           clock,
  input  logic                           reset,
  input  icache_pkg::mem_cmd_e           mem_cmd,
  input  logic [icache_pkg::PADDR_W-1:0] mem_addr,
  input  logic [icache_pkg::DATA_W-1:0]  prdata,
  input  logic                           pready,
  output icache_pkg::mem_rsp_t           mem_rsp,
  output icache_pkg::apb_req_t           apb
);

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2,
    RESP   = 2'd3
  } state_e;

  state_e state, state_next;

  logic [icache_pkg::RSP_TAG_W-1:0] next_tag;  // rotates 1..15
  logic [icache_pkg::RSP_TAG_W-1:0] cur_tag;
  logic [icache_pkg::PADDR_W-1:0]   addr_q;
  logic [icache_pkg::DATA_W-1:0]    data_q;
  logic                             take;

  // only an idle bridge accepts, so busy cycles answer with response zero
  assign take = (state == IDLE) && (mem_cmd == icache_pkg::BUS_LOAD);

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:    if (take) state_next = SETUP;
      SETUP:   state_next = ACCESS;
      ACCESS:  if (pready) state_next = RESP;
      RESP:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state    <= IDLE;
      next_tag <= 4'd1;
    end
    else
    begin
      state <= state_next;
      if (take)
        next_tag <= (next_tag == '1) ? 4'd1 : next_tag + 4'd1;  // skip zero
    end
  end

  always_ff @(posedge clock)
  begin
    if (take)
    begin
      addr_q  <= mem_addr;
      cur_tag <= next_tag;
    end
    if ((state == ACCESS) && pready)
      data_q <= prdata;  // returned one cycle later
  end

  always_comb
  begin
    mem_rsp.response = take ? next_tag : '0;
    mem_rsp.tag      = (state == RESP) ? cur_tag : '0;
    mem_rsp.data     = (state == RESP) ? data_q : '0;
  end

  always_comb
  begin
    apb.paddr   = addr_q;
    apb.psel    = (state == SETUP) || (state == ACCESS);
    apb.penable = (state == ACCESS);
    apb.pwrite  = 1'b0;  // read only
  end

endmodule

//--- tb.f
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_mem.sv
hw/imem_apb_bridge.sv
hw/icache_top.sv
tb/icache_tb.sv

//--- tb/icache_stim.txt
// op (F fetch, S abandoned fetch, R reset)  fetch address  expected data  new APB transfers
// data is {~A, A} for the word address A; an R line presents its address during reset
F 0000000000001000 ffffefff00001000 1
F 0000000000001000 ffffefff00001000 0
F 0000000000001005 ffffefff00001000 0
F 0000000000001018 ffffefe700001018 1
F 000000000000101f ffffefe700001018 0
F 0000000000001100 ffffeeff00001100 1
F 0000000000001000 ffffefff00001000 1
F 0000000000001100 ffffeeff00001100 1
F 0000000000001018 ffffefe700001018 0
S 0000000000002040 ffffdfbf00002040 0
F 0000000000003088 ffffcf7700003088 2
F 0000000000002040 ffffdfbf00002040 0
S 00000000000040f0 ffffbf0f000040f0 0
F 00000000000040f0 ffffbf0f000040f0 1
F 00000000000040f4 ffffbf0f000040f0 0
R 0000000000001000 0000000000000000 0
F 0000000000001000 ffffefff00001000 1
F 0000000000001018 ffffefe700001018 1
F 0000000000001000 ffffefff00001000 0
F 000000007ffffff8 800000077ffffff8 1
F 00000000deadbee8 21524117deadbee8 1
F 00000000deadbeef 21524117deadbee8 0
F 0000000000000ff8 fffff00700000ff8 1
F 000000007ffffffc 800000077ffffff8 1
S 0000000000005010 ffffafef00005010 0
F 0000000000006020 ffff9fdf00006020 2
F 0000000000005010 ffffafef00005010 0
F 0000000000006024 ffff9fdf00006020 0

//--- tb/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;

  localparam int    CLK_PERIOD   = 4;
  localparam int    RESET_CYCLES = 5;
  localparam int    OP_CYCLES    = 60;  // cycle budget per stimulus line
  localparam string STIM_FILE    = "tb/icache_stim.txt";

  logic                 clock;
  logic                 reset;
  logic [63:0]          fetch_addr;
  logic [63:0]          prdata;
  logic                 pready;
  logic [63:0]          fetch_data;
  logic                 fetch_valid;
  icache_pkg::apb_req_t apb;

  logic [7:0]  op_q[$];  // F fetch, S abandoned fetch, R reset
  logic [63:0] addr_q[$];
  logic [63:0] data_q[$];
  int          count_q[$];  // expected new APB transfers
  int          num_ops = 0;
  bit          loaded = 1'b0;

  int          error_count = 0;
  int          check_count = 0;
  int          xfer_count = 0;
  int          last_count = 0;
  int          wait_states = 0;
  logic [31:0] last_paddr = '0;

  icache_top #(
    .NUM_LINES (32)
  ) dut0 (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .prdata      (prdata),
    .pready      (pready),
    .fetch_data  (fetch_data),
    .fetch_valid (fetch_valid),
    .apb         (apb)
  );

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  // APB slave, word address A reads back as {~A, A}
  always @(negedge clock)
  begin
    if (apb.psel && apb.penable)
    begin
      if (apb.pwrite)
      begin
        $display("Error: apb pwrite expected 0 actual 1");
        error_count++;
      end
      if (wait_states == 0)
      begin
        pready     = 1'b1;
        prdata     = {~apb.paddr, apb.paddr};
        last_paddr = apb.paddr;
        xfer_count++;  // completes at the coming rising edge
      end
      else
        wait_states--;
    end
    else
    begin
      if (apb.psel)
        wait_states = int'($urandom % 4);  // setup phase picks the delay
      pready = 1'b0;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Error: %s expected %0h actual %0h", name, exp, act);
    error_count++;
  endtask

  task automatic check_transfers(input int idx, input string name);
    int delta;
    delta = xfer_count - last_count;
    last_count = xfer_count;
    check_count++;
    if (delta != count_q[idx])
      report_mismatch({name, " apb transfers"}, 64'(count_q[idx]), 64'(delta));
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [63:0] addr;
    logic [63:0] data;
    int          count;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      error_count++;
      return;
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "/")
        continue;  // blank or comment
      n = $sscanf(line, "%c %h %h %d", op, addr, data, count);
      if (n != 4)
      begin
        $display("Could not parse stimulus line: %s", line);
        error_count++;
      end
      else
      begin
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        count_q.push_back(count);
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_reset(input int cycles);
    reset = 1'b1;
    repeat (cycles) @(negedge clock);
    reset = 1'b0;
  endtask

  task automatic run_fetch(input int idx);
    int          waited;
    string       name;
    logic [31:0] exp_paddr;
    name = $sformatf("line %0d fetch %h", idx, addr_q[idx]);
    exp_paddr = data_q[idx][31:0];  // low word of {~A, A} is the word address
    waited = 0;
    fetch_addr = addr_q[idx];
    #1;
    while (!fetch_valid)
    begin
      @(negedge clock);
      #1;
      waited++;
    end
    check_count++;
    if (fetch_data !== data_q[idx])
      report_mismatch({name, " data"}, data_q[idx], fetch_data);
    check_transfers(idx, name);
    if (count_q[idx] == 0 && waited != 0)
    begin
      $display("%s hit but fetch_valid came %0d cycles late", name, waited);
      error_count++;
    end
    if (count_q[idx] != 0 && last_paddr != exp_paddr)
      report_mismatch({name, " paddr"}, 64'(exp_paddr), 64'(last_paddr));
  endtask

  task automatic run_abandon(input int idx);
    fetch_addr = addr_q[idx];
    @(negedge clock);  // address stands for two cycles
    #1;
    check_transfers(idx, $sformatf("line %0d abandon %h", idx, addr_q[idx]));
  endtask

  task automatic run_reset_op(input int idx);
    fetch_addr = addr_q[idx];  // next fetch address waits behind reset
    apply_reset(RESET_CYCLES);
    #1;
    check_transfers(idx, $sformatf("line %0d reset", idx));
  endtask

  initial
  begin
    reset      = 1'b1;
    fetch_addr = '0;
    prdata     = '0;
    pready     = 1'b0;
    void'($urandom(32'h2572));
    load_stimulus();
    num_ops = op_q.size();
    if (num_ops == 0)
    begin
      $display("No stimulus lines were loaded");
      error_count++;
    end
    else
      fetch_addr = addr_q[0];  // first address is presented out of reset
    loaded = 1'b1;
    apply_reset(RESET_CYCLES);
    for (int i = 0; i < num_ops; i++)
    begin
      @(negedge clock);
      case (op_q[i])
        "F": run_fetch(i);
        "S": run_abandon(i);
        "R": run_reset_op(i);
        default:
        begin
          $display("Unknown operation on stimulus line %0d", i);
          error_count++;
        end
      endcase
    end
    $display("checks: %0d errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    wait (loaded);
    #((num_ops + RESET_CYCLES) * OP_CYCLES * CLK_PERIOD);
    $display("Timeout: the fetch sequence did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

endmodule
